// ==== alien_formation.f ====
src/invader_pkg.sv
src/step_timer.sv
src/formation_motion.sv
src/alien_slot_decode.sv
src/alien_bitmap_render.sv
src/alien_formation.sv
tb/tb_alien_formation.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the alien formation testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_alien_formation

verilator --binary --timing --assert -Wno-fatal \
    -f alien_formation.f \
    --top-module tb_alien_formation \
    -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** PASSED ***" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== src/alien_bitmap_render.sv ====
/* Alien shape lookup with the registered pixel value and
   per-alien active vector */
`timescale 1ns/1ps
`default_nettype none

module alien_bitmap_render (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [invader_pkg::NUM_ALIENS-1:0] slot_hit,
    input  logic [invader_pkg::LOCAL_W-1:0]    local_row,
    input  logic [invader_pkg::LOCAL_W-1:0]    local_col,
    output logic [invader_pkg::PIX_W-1:0]      alien_pixel,
    output logic [invader_pkg::NUM_ALIENS-1:0] alien_active
);

    logic [(1 << invader_pkg::LOCAL_W)-1:0] row_mask;
    logic                                   shape_lit;

    // Shape is drawn in row pairs with bit n of the mask as local column n
    always_comb
    begin
        case (local_row[invader_pkg::LOCAL_W-1:1])
            3'd0:    row_mask = 16'h03C0;
            3'd1:    row_mask = 16'h0FF0;
            3'd2:    row_mask = 16'h3FFC;
            // Eyes
            3'd3:    row_mask = 16'hF3CF;
            3'd4:    row_mask = 16'hFFFF;
            3'd5:    row_mask = 16'h0C30;
            // Legs
            3'd6:    row_mask = 16'h33CC;
            3'd7:    row_mask = 16'hCC33;
            default: row_mask = '0;
        endcase
    end

    assign shape_lit = (|slot_hit) && row_mask[local_col];

    // One stage between the coordinate and the VGA pixel
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            alien_pixel  <= '0;
            alien_active <= '0;
        end
        else
        begin
            alien_pixel  <= shape_lit ? invader_pkg::PIX_LIT : '0;
            alien_active <= slot_hit;
        end
    end

    // Boxes never overlap so the decode hits one alien at most
    a_active_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(alien_active)
    );

endmodule

`default_nettype wire

// ==== src/alien_formation.sv ====
/* Top level of the five-alien formation: step timer, motion,
   box decode and bitmap render */
`timescale 1ns/1ps
`default_nettype none

module alien_formation #(
    parameter logic [invader_pkg::STEP_CNT_W-1:0] STEP_CYCLES =
        invader_pkg::STEP_CYCLES_DEFAULT
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [invader_pkg::COORD_W-1:0]    pixel_row,
    input  logic [invader_pkg::COORD_W-1:0]    pixel_column,
    output logic [invader_pkg::PIX_W-1:0]      alien_pixel,
    output logic [invader_pkg::NUM_ALIENS-1:0] alien_active,
    output logic                               loser
);

    logic                               step;
    logic [invader_pkg::COORD_W-1:0]    sprite_row;
    logic [invader_pkg::COORD_W-1:0]    sprite_column;
    logic [invader_pkg::NUM_ALIENS-1:0] slot_hit;
    logic [invader_pkg::LOCAL_W-1:0]    local_row;
    logic [invader_pkg::LOCAL_W-1:0]    local_col;

    step_timer #(
        .STEP_CYCLES (STEP_CYCLES)
    ) step_timer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step)
    );

    formation_motion formation_motion_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .step          (step),
        .sprite_row    (sprite_row),
        .sprite_column (sprite_column),
        .loser         (loser)
    );

    // Decode is combinational, against the origin held this cycle
    alien_slot_decode alien_slot_decode_inst (
        .pixel_row     (pixel_row),
        .pixel_column  (pixel_column),
        .sprite_row    (sprite_row),
        .sprite_column (sprite_column),
        .slot_hit      (slot_hit),
        .local_row     (local_row),
        .local_col     (local_col)
    );

    alien_bitmap_render alien_bitmap_render_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_hit     (slot_hit),
        .local_row    (local_row),
        .local_col    (local_col),
        .alien_pixel  (alien_pixel),
        .alien_active (alien_active)
    );

endmodule

`default_nettype wire

// ==== src/alien_slot_decode.sv ====
/* Alien box decode: which sprite holds the pixel and the local
   row and column inside it */
`timescale 1ns/1ps
`default_nettype none

module alien_slot_decode (
    input  logic [invader_pkg::COORD_W-1:0]    pixel_row,
    input  logic [invader_pkg::COORD_W-1:0]    pixel_column,
    input  logic [invader_pkg::COORD_W-1:0]    sprite_row,
    input  logic [invader_pkg::COORD_W-1:0]    sprite_column,
    output logic [invader_pkg::NUM_ALIENS-1:0] slot_hit,
    output logic [invader_pkg::LOCAL_W-1:0]    local_row,
    output logic [invader_pkg::LOCAL_W-1:0]    local_col
);

    logic [invader_pkg::COORD_W-1:0] row_off;
    logic [invader_pkg::COORD_W-1:0] col_off;
    logic [invader_pkg::COORD_W-1:0] slot_base;
    logic [invader_pkg::COORD_W-1:0] slot_off;
    logic                            row_in_band;

    // Sprite occupies origin+1 .. origin+16 on both axes
    assign row_off = pixel_row - sprite_row - 1'b1;
    assign col_off = pixel_column - sprite_column - 1'b1;

    // Pixels above or left of the origin wrap to large offsets
    assign row_in_band = (row_off < invader_pkg::SPRITE_SIZE);

    assign local_row = row_off[invader_pkg::LOCAL_W-1:0];

    // Walk the five boxes, each one pitch further right
    always_comb
    begin
        slot_hit  = '0;
        local_col = '0;
        slot_base = '0;
        slot_off  = col_off;

        for (int k = 0; k < invader_pkg::NUM_ALIENS; k++)
        begin
            slot_off = col_off - slot_base;
            if (row_in_band && (slot_off < invader_pkg::SPRITE_SIZE))
            begin
                slot_hit[k] = 1'b1;
                local_col   = slot_off[invader_pkg::LOCAL_W-1:0];
            end
            slot_base = slot_base + invader_pkg::ALIEN_PITCH;
        end
    end

    // The 4 column gap between boxes leaves every hit bit clear

endmodule

`default_nettype wire

// ==== src/formation_motion.sv ====
/* Formation origin registers, travel direction and loser flag,
   advanced once per motion step */
`timescale 1ns/1ps
`default_nettype none

module formation_motion (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             step,
    output logic [invader_pkg::COORD_W-1:0]  sprite_row,
    output logic [invader_pkg::COORD_W-1:0]  sprite_column,
    output logic                             loser
);

    logic                            move_left;
    logic                            move_left_next;
    logic [invader_pkg::COORD_W-1:0] row_next;
    logic [invader_pkg::COORD_W-1:0] column_next;

    // Next origin and direction for the coming step
    always_comb
    begin
        row_next       = sprite_row;
        column_next    = sprite_column;
        move_left_next = move_left;

        if (move_left)
        begin
            if (sprite_column < invader_pkg::LEFT_LIMIT)
            begin
                // Past the left edge drop and head right
                row_next       = sprite_row + invader_pkg::DROP_ROWS;
                move_left_next = 1'b0;
            end
            else
            begin
                column_next = sprite_column - invader_pkg::STEP_COLS;
            end
        end
        else
        begin
            if (sprite_column > invader_pkg::RIGHT_LIMIT)
            begin
                // Past the right edge the column holds for this step
                row_next       = sprite_row + invader_pkg::DROP_ROWS;
                move_left_next = 1'b1;
            end
            else
            begin
                column_next = sprite_column + invader_pkg::STEP_COLS;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sprite_row    <= invader_pkg::HOME_ROW;
            sprite_column <= invader_pkg::HOME_COL;
            move_left     <= 1'b0;
        end
        else if (step)
        begin
            sprite_row    <= row_next;
            sprite_column <= column_next;
            move_left     <= move_left_next;
        end
    end

    // Formation has reached the defenders
    assign loser = (sprite_row > invader_pkg::LOSE_ROW);

    // Column only moves on the edge that closes a step cycle
    a_column_on_step : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(sprite_column) |-> $past(step)
    );

endmodule

`default_nettype wire

// ==== src/invader_pkg.sv ====
/* Screen, sprite, formation and motion constants shared by the
   alien formation blocks */
`default_nettype none

package invader_pkg;

    // Coordinate and pixel widths
    localparam int COORD_W = 12;
    localparam int PIX_W   = 4;
    localparam int LOCAL_W = 4;

    localparam logic [PIX_W-1:0] PIX_LIT = 4'hF;

    // Formation layout
    localparam int NUM_ALIENS = 5;
    localparam logic [COORD_W-1:0] SPRITE_SIZE = 12'd16;
    // 16 pixel sprite plus a 4 pixel gap
    localparam logic [COORD_W-1:0] ALIEN_PITCH = 12'd20;

    // Origin after reset, roughly centered near the top
    localparam logic [COORD_W-1:0] HOME_ROW = 12'd20;
    localparam logic [COORD_W-1:0] HOME_COL = 12'd312;

    // Motion rule
    localparam logic [COORD_W-1:0] STEP_COLS   = 12'd12;
    localparam logic [COORD_W-1:0] DROP_ROWS   = 12'd24;
    localparam logic [COORD_W-1:0] LEFT_LIMIT  = 12'd21;
    localparam logic [COORD_W-1:0] RIGHT_LIMIT = 12'd560;
    localparam logic [COORD_W-1:0] LOSE_ROW    = 12'd460;

    // Step period, about half a second at 31.5 MHz
    localparam int STEP_CNT_W = 24;
    localparam logic [STEP_CNT_W-1:0] STEP_CYCLES_DEFAULT = 24'd16_000_000;

endpackage

`default_nettype wire

// ==== src/step_timer.sv ====
/* Free-running step counter with a one-cycle pulse per period */
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
    parameter logic [invader_pkg::STEP_CNT_W-1:0] STEP_CYCLES =
        invader_pkg::STEP_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic rst_n,
    output logic step
);

    logic [invader_pkg::STEP_CNT_W-1:0] step_cnt;

    // Pulse on the last count of the period
    assign step = (step_cnt == STEP_CYCLES - 1'b1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            step_cnt <= '0;
        end
        else if (step)
        begin
            step_cnt <= '0;
        end
        else
        begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Wrap must leave a gap between pulses
    a_step_single_cycle : assert property (
        @(posedge clk) disable iff (!rst_n)
        (step && (STEP_CYCLES > 1)) |=> !step
    );

endmodule

`default_nettype wire

// ==== tb/alien_formation_input.txt ====
# test steps row_off col_off pixel(hex) active(hex)
# steps to wait before the probe; offsets are from the formation origin
1 0 40 200 0 00
1 0 1 7 f 01
1 0 1 27 f 02
2 0 9 1 f 01
2 0 1 1 0 01
2 0 16 1 f 01
2 0 7 25 0 02
2 0 16 36 f 02
2 0 11 51 f 04
2 0 4 44 0 04
2 0 13 68 f 08
2 0 15 63 0 08
2 0 5 83 f 10
2 0 12 87 0 10
2 0 1 90 f 10
3 0 5 17 0 00
3 0 5 20 0 00
3 0 9 77 0 00
3 0 9 97 0 00
3 0 0 7 0 00
3 0 17 7 0 00
3 0 5 0 0 00
4 1 1 7 f 01
4 0 9 48 f 04
4 4 7 5 0 01
4 0 13 23 f 02
5 21 1 7 f 01
5 0 16 95 f 10
5 3 9 16 f 01
5 0 3 47 f 04
6 800 1 7 f 01
6 0 9 88 f 10
6 40 1 7 f 01
6 0 9 88 f 10

// ==== tb/tb_alien_formation.sv ====
/* Testbench for the alien formation: probe file reader, motion model,
   output checks and pass/fail report */
`timescale 1ns/1ps
`default_nettype none

module tb_alien_formation;

    localparam int STEP_CYCLES  = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int GAP_PROBES   = 8;

    // Motion rule values as plain integers for the model
    localparam int HOME_ROW    = int'(invader_pkg::HOME_ROW);
    localparam int HOME_COL    = int'(invader_pkg::HOME_COL);
    localparam int STEP_COLS   = int'(invader_pkg::STEP_COLS);
    localparam int DROP_ROWS   = int'(invader_pkg::DROP_ROWS);
    localparam int LEFT_LIMIT  = int'(invader_pkg::LEFT_LIMIT);
    localparam int RIGHT_LIMIT = int'(invader_pkg::RIGHT_LIMIT);
    localparam int LOSE_ROW    = int'(invader_pkg::LOSE_ROW);

    logic                               clk;
    logic                               rst_n;
    logic [invader_pkg::COORD_W-1:0]    pixel_row;
    logic [invader_pkg::COORD_W-1:0]    pixel_column;
    logic [invader_pkg::PIX_W-1:0]      alien_pixel;
    logic [invader_pkg::NUM_ALIENS-1:0] alien_active;
    logic                               loser;

    // Model of the formation origin and direction
    int cyc;
    int model_steps;
    int model_row;
    int model_col;
    bit model_left;

    int cur_test;
    int test_probes;
    int test_errors;
    int total_probes;
    int total_errors;
    int tests_done;

    // Probe table from the input file
    int probe_test[$];
    int probe_steps[$];
    int probe_row[$];
    int probe_col[$];
    int probe_pix[$];
    int probe_act[$];

    bit     run_ready;
    longint watchdog_ns;

    alien_formation #(
        .STEP_CYCLES (STEP_CYCLES)
    ) alien_formation_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .alien_pixel  (alien_pixel),
        .alien_active (alien_active),
        .loser        (loser)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        wait (run_ready);
        #(watchdog_ns);
        $display("ERROR: watchdog expired after %0d ns, test %0d never finished",
                 watchdog_ns, cur_test);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        cyc++;
    endtask

    task automatic apply_step();
        if (model_left)
        begin
            if (model_col < LEFT_LIMIT)
            begin
                model_row  = model_row + DROP_ROWS;
                model_left = 1'b0;
            end
            else
            begin
                model_col = model_col - STEP_COLS;
            end
        end
        else
        begin
            if (model_col > RIGHT_LIMIT)
            begin
                model_row  = model_row + DROP_ROWS;
                model_left = 1'b1;
            end
            else
            begin
                model_col = model_col + STEP_COLS;
            end
        end
        model_steps++;
    endtask

    // A step lands on every STEP_CYCLES-th edge after reset release
    task automatic sync_model();
        while (model_steps < cyc / STEP_CYCLES)
        begin
            apply_step();
        end
    endtask

    task automatic wait_steps(input int count);
        int target;
        sync_model();
        target = model_steps + count;
        while (cyc / STEP_CYCLES < target)
        begin
            next_cycle();
        end
        sync_model();
    endtask

    task automatic report_mismatch(input string sig, input int expected, input int actual);
        $display("FAIL test %0d: %s expected 0x%0h, got 0x%0h (origin row %0d col %0d)",
                 cur_test, sig, expected, actual, model_row, model_col);
        test_errors++;
    endtask

    task automatic run_probe(input int row_off, input int col_off,
                             input int exp_pix, input int exp_act);
        int  prow;
        int  pcol;
        bit  exp_loser;
        sync_model();
        prow         = model_row + row_off;
        pcol         = model_col + col_off;
        exp_loser    = (model_row > LOSE_ROW);
        pixel_row    = prow[invader_pkg::COORD_W-1:0];
        pixel_column = pcol[invader_pkg::COORD_W-1:0];
        if (loser !== exp_loser)
        begin
            report_mismatch("loser", int'(exp_loser), int'(loser));
        end
        // Registered outputs show this coordinate one edge later
        next_cycle();
        if (alien_pixel !== exp_pix[invader_pkg::PIX_W-1:0])
        begin
            report_mismatch("alien_pixel", exp_pix, int'(alien_pixel));
        end
        if (alien_active !== exp_act[invader_pkg::NUM_ALIENS-1:0])
        begin
            report_mismatch("alien_active", exp_act, int'(alien_active));
        end
        test_probes++;
    endtask

    // Gaps sit at column offsets 17..20 past each of the first four aliens
    task automatic random_gap_probes(input int count);
        int gap;
        int off;
        int row;
        for (int i = 0; i < count; i++)
        begin
            gap = $urandom % 4;
            off = $urandom % 4;
            row = 1 + ($urandom % 16);
            run_probe(row, 17 + 20 * gap + off, 0, 0);
        end
    endtask

    task automatic close_test();
        if (cur_test == 3)
        begin
            random_gap_probes(GAP_PROBES);
        end
        $display("test %0d done: %0d probes, %0d errors, origin row %0d col %0d, step %0d",
                 cur_test, test_probes, test_errors, model_row, model_col, model_steps);
        total_probes = total_probes + test_probes;
        total_errors = total_errors + test_errors;
        tests_done++;
        test_probes = 0;
        test_errors = 0;
    endtask

    task automatic load_probes(output bit ok);
        int    fd;
        int    n;
        int    t;
        int    s;
        int    r;
        int    c;
        int    p;
        int    a;
        string line;
        ok = 1'b1;
        fd = $fopen("tb/alien_formation_input.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the probe file tb/alien_formation_input.txt");
            ok = 1'b0;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 2 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%d %d %d %d %h %h", t, s, r, c, p, a);
                    if (n == 6)
                    begin
                        probe_test.push_back(t);
                        probe_steps.push_back(s);
                        probe_row.push_back(r);
                        probe_col.push_back(c);
                        probe_pix.push_back(p);
                        probe_act.push_back(a);
                    end
                    else
                    begin
                        $display("ERROR: malformed probe line: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (probe_test.size() == 0)
            begin
                $display("ERROR: the probe file holds no probes");
                ok = 1'b0;
            end
        end
    endtask

    task automatic run_tests();
        longint sum_steps;
        sum_steps = 0;
        foreach (probe_steps[i])
        begin
            sum_steps = sum_steps + probe_steps[i];
        end
        watchdog_ns = (sum_steps + probe_test.size() + GAP_PROBES + 100)
                      * STEP_CYCLES * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
        run_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        cyc   = 0;

        // Reset values before any probe
        cur_test = probe_test[0];
        if (alien_pixel !== '0)
        begin
            report_mismatch("alien_pixel", 0, int'(alien_pixel));
        end
        if (alien_active !== '0)
        begin
            report_mismatch("alien_active", 0, int'(alien_active));
        end
        if (loser !== 1'b0)
        begin
            report_mismatch("loser", 0, int'(loser));
        end

        foreach (probe_test[i])
        begin
            if (probe_test[i] != cur_test)
            begin
                close_test();
                cur_test = probe_test[i];
            end
            wait_steps(probe_steps[i]);
            run_probe(probe_row[i], probe_col[i], probe_pix[i], probe_act[i]);
        end
        close_test();

        $display("summary: %0d tests, %0d probes, %0d errors",
                 tests_done, total_probes, total_errors);
        if (total_errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial
    begin
        bit load_ok;
        void'($urandom(91));
        rst_n        = 1'b0;
        pixel_row    = '0;
        pixel_column = '0;
        cyc          = 0;
        model_steps  = 0;
        model_row    = HOME_ROW;
        model_col    = HOME_COL;
        model_left   = 1'b0;
        cur_test     = 0;
        test_probes  = 0;
        test_errors  = 0;
        total_probes = 0;
        total_errors = 0;
        tests_done   = 0;
        run_ready    = 1'b0;
        watchdog_ns  = 0;
        load_probes(load_ok);
        if (!load_ok)
        begin
            $display("*** FAILED ***");
            $finish;
        end
        else
        begin
            run_tests();
        end
    end

endmodule

`default_nettype wire
